// File: Makefile
# Verilator simulation of the debug message port

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails if any check fails"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/VdebugTb: compile.f debug_consts.svh $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module debugTb -Mdir obj_dir

test: obj_dir/VdebugTb
	./obj_dir/VdebugTb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

// File: cmdHandler.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_consts.svh"

module cmdHandler import debugPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  msgFrame_t popData,
    input  logic      empty,
    output logic      popReady,
    msgIf.source      reply,
    output logic      led0
);

    cmdState_t state;
    msgType_t inType;
    payloadLen_t inLen;
    payload_t inPayload;

    assign inType = popData[7:0];
    assign inLen = popData[15:8];
    assign inPayload = popData[$bits(msgFrame_t)-1:16];

    // Pop the head message as soon as one is waiting
    assign popReady = (state == cmdWait) && !empty;
    assign reply.valid = (state == cmdReply);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cmdWait;
            led0 <= 1'b0;
        end else begin
            case (state)
                cmdWait: begin
                    if (!empty) begin
                        if (inType == `MSG_TYPE_SET_LED) begin
                            led0 <= inPayload[0];
                        end
                        state <= cmdReply;
                    end
                end
                cmdReply: begin
                    if (reply.ready) begin
                        state <= cmdWait;
                    end
                end
                default: state <= cmdWait;
            endcase
        end
    end

    // Reply fields, held until the sequencer takes them
    always_ff @(posedge clk) begin
        if (popReady) begin
            reply.msgType <= inType;
            case (inType)
                `MSG_TYPE_SET_LED: begin
                    reply.payloadLen <= 8'd1;
                    reply.payload <= payload_t'(inPayload[0]);
                end
                `MSG_TYPE_ECHO: begin
                    reply.payloadLen <= inLen;
                    reply.payload <= inPayload;
                end
                // Unknown types are acknowledged with an empty payload
                default: begin
                    reply.payloadLen <= '0;
                    reply.payload <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
debugPkg.sv
msgIf.sv
msgFifo.sv
serialRx.sv
serialTx.sv
msgSender.sv
cmdHandler.sv
debugTop.sv
debugTb.sv

// File: debugPkg.sv
`default_nettype none
`include "debug_consts.svh"

package debugPkg;

    // One byte on the serial link
    typedef logic [7:0] byte_t;
    typedef logic [7:0] msgType_t;
    // Length field as received, may exceed what is stored
    typedef logic [7:0] payloadLen_t;
    // Payload byte 0 sits in the low bits
    typedef logic [`DEBUG_MAX_PAYLOAD*8-1:0] payload_t;
    // Incoming queue word laid out as {payload, stored length, type}
    typedef logic [$bits(payload_t)+15:0] msgFrame_t;

    typedef enum logic [2:0] {
        rxIdle,
        rxType,
        rxLen,
        rxPayload,
        rxPush
    } rxState_t;

    typedef enum logic [1:0] {
        sendIdle,
        sendType,
        sendLen,
        sendPayload
    } sendState_t;

    typedef enum logic {
        cmdWait,
        cmdReply
    } cmdState_t;

endpackage

`default_nettype wire

// File: debugTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_consts.svh"

module debugTb;

    localparam int CLK_PERIOD_NS = 40;
    localparam int HALF_CLKS = 6;
    localparam int BIT_PERIOD_NS = 2 * HALF_CLKS * CLK_PERIOD_NS;
    localparam int DRAIN_LIMIT = 40;
    localparam int TAIL_BYTES = 2;
    // Upper bound on bytes sent by the six tests, drains counted separately
    localparam int SEND_BYTES = 160;
    localparam int DRAIN_CALLS = 9;
    localparam int SERIAL_BYTES = SEND_BYTES + DRAIN_CALLS * (DRAIN_LIMIT + TAIL_BYTES);
    localparam int WATCHDOG_NS = SERIAL_BYTES * 8 * BIT_PERIOD_NS * 4;

    typedef enum {parseIdle, parseLen, parsePayload} parseState_t;

    logic clk;
    logic arstN;
    logic debugClk;
    logic debugCs;
    logic debugDi;
    logic debugDo;
    logic led0;

    int seed = 32022;
    int checkCount = 0;
    int errorCount = 0;
    int testIndex = 0;
    int testStartChecks;
    int testStartErrors;

    // Model state: bytes to send and replies in order, {payload, length, type}
    logic [7:0] txBytes[$];
    logic [55:0] expReplies[$];
    logic modelLed = 1'b0;

    // Output stream parser
    parseState_t parseState = parseIdle;
    logic [7:0] curType;
    logic [7:0] curLen;
    logic [7:0] curBytes[$];

    debugTop dut_i (
        .clk      (clk),
        .arstN    (arstN),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .debugDo  (debugDo),
        .led0     (led0)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    function automatic int randRange(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % 32'(hi - lo + 1));
    endfunction

    task automatic reportMismatch(input string name, input logic [39:0] expValue,
                                  input logic [39:0] gotValue);
        errorCount++;
        $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expValue,
                 gotValue);
    endtask

    // ==================================================================
    // Serial master
    // ==================================================================
    // Entered right after a rising clk edge, leaves debugClk falling
    task automatic exchangeByte(input logic [7:0] txByte, output logic [7:0] rxByte);
        int i;
        for (i = 7; i >= 0; i--) begin
            debugDi <= txByte[i];
            repeat (HALF_CLKS) @(posedge clk);
            debugClk <= 1'b1;
            repeat (HALF_CLKS - 1) @(posedge clk);
            // debugDo settled 3 clk after the rising edge
            @(negedge clk);
            rxByte[i] = debugDo;
            @(posedge clk);
            debugClk <= 1'b0;
        end
    endtask

    task automatic finishReply();
        logic [55:0] expWord;
        int i;
        parseState = parseIdle;
        if (expReplies.size() == 0) begin
            errorCount++;
            $display("Unexpected reply of type %0h at %0t ns with no request pending",
                     curType, $time);
        end else begin
            expWord = expReplies.pop_front();
            checkCount++;
            if (curType !== expWord[7:0]) begin
                reportMismatch("reply type", expWord[7:0], curType);
            end
            checkCount++;
            if (curLen !== expWord[15:8]) begin
                reportMismatch("reply length", expWord[15:8], curLen);
            end else begin
                for (i = 0; i < curLen; i++) begin
                    checkCount++;
                    if (curBytes[i] !== expWord[16 + i * 8 +: 8]) begin
                        reportMismatch("reply payload byte", expWord[16 + i * 8 +: 8],
                                       curBytes[i]);
                    end
                end
            end
        end
    endtask

    // Zero bytes are fill until a nonzero type byte starts a reply
    task automatic parseByte(input logic [7:0] rxByte);
        case (parseState)
            parseIdle: begin
                if (rxByte != 8'h00) begin
                    curType = rxByte;
                    parseState = parseLen;
                end
            end
            parseLen: begin
                curLen = rxByte;
                curBytes.delete();
                if (rxByte == 8'h00) begin
                    finishReply();
                end else begin
                    parseState = parsePayload;
                end
            end
            default: begin
                curBytes.push_back(rxByte);
                if (curBytes.size() == int'(curLen)) begin
                    finishReply();
                end
            end
        endcase
    endtask

    task automatic transferByte(input logic [7:0] txByte);
        logic [7:0] rxByte;
        exchangeByte(txByte, rxByte);
        parseByte(rxByte);
    endtask

    task automatic sendQueued();
        while (txBytes.size() != 0) begin
            transferByte(txBytes.pop_front());
        end
    endtask

    // ==================================================================
    // Reference model
    // ==================================================================
    task automatic queueMessage(input logic [7:0] msgType, input int len);
        logic [39:0] kept;
        logic [7:0] dataByte;
        logic [7:0] replyLen;
        int i;
        kept = '0;
        txBytes.push_back(msgType);
        txBytes.push_back(8'(len));
        for (i = 0; i < len; i++) begin
            dataByte = 8'($random(seed));
            txBytes.push_back(dataByte);
            if (i < `DEBUG_MAX_PAYLOAD) begin
                kept[i * 8 +: 8] = dataByte;
            end
        end
        if (msgType == `MSG_TYPE_SET_LED) begin
            modelLed = kept[0];
            expReplies.push_back({39'd0, modelLed, 8'd1, msgType});
        end else if (msgType == `MSG_TYPE_ECHO) begin
            replyLen = (len > `DEBUG_MAX_PAYLOAD) ? 8'(`DEBUG_MAX_PAYLOAD) : 8'(len);
            expReplies.push_back({kept, replyLen, msgType});
        end else begin
            // Unknown type gets an empty acknowledge
            expReplies.push_back({40'd0, 8'd0, msgType});
        end
    endtask

    task automatic drainReplies();
        logic [7:0] rxByte;
        int n;
        n = 0;
        while ((expReplies.size() != 0 || parseState != parseIdle) && n < DRAIN_LIMIT) begin
            transferByte(8'h00);
            n++;
        end
        if (expReplies.size() != 0 || parseState != parseIdle) begin
            errorCount++;
            $display("Reply missing at %0t ns, %0d replies never arrived", $time,
                     expReplies.size());
            expReplies.delete();
            parseState = parseIdle;
        end
        // Empty outgoing queue means zero fill only
        repeat (TAIL_BYTES) begin
            exchangeByte(8'h00, rxByte);
            checkCount++;
            if (rxByte !== 8'h00) begin
                reportMismatch("debugDo idle byte", 8'h00, rxByte);
            end
        end
    endtask

    task automatic startTest();
        testIndex++;
        testStartChecks = checkCount;
        testStartErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        $display("Test %0d %s finished: %0d checks, %0d errors", testIndex, name,
                 checkCount - testStartChecks, errorCount - testStartErrors);
    endtask

    // ==================================================================
    // Tests
    // ==================================================================
    initial begin
        int i;
        arstN = 1'b0;
        debugClk = 1'b0;
        debugCs = 1'b0;
        debugDi = 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        debugCs <= 1'b1;
        repeat (HALF_CLKS) @(posedge clk);

        startTest();
        for (i = 0; i < 4; i++) begin
            queueMessage(`MSG_TYPE_SET_LED, 1);
            sendQueued();
            drainReplies();
            @(negedge clk);
            checkCount++;
            if (led0 !== modelLed) begin
                reportMismatch("led0", modelLed, led0);
            end
            @(posedge clk);
        end
        endTest("SetLED");

        startTest();
        for (i = 0; i < 6; i++) begin
            queueMessage(`MSG_TYPE_ECHO, randRange(0, 5));
        end
        sendQueued();
        drainReplies();
        endTest("Echo");

        startTest();
        queueMessage(`MSG_TYPE_ECHO, randRange(6, 10));
        queueMessage(`MSG_TYPE_ECHO, randRange(0, 5));
        sendQueued();
        drainReplies();
        endTest("Echo overflow");

        startTest();
        for (i = 0; i < 6; i++) begin
            repeat (randRange(0, 3)) txBytes.push_back(`MSG_TYPE_NOP);
            queueMessage(8'(randRange(3, 255)), randRange(0, 3));
        end
        sendQueued();
        drainReplies();
        endTest("Nop and unknown types");

        startTest();
        for (i = 0; i < 4; i++) begin
            queueMessage(`MSG_TYPE_ECHO, 5);
        end
        sendQueued();
        drainReplies();
        endTest("Burst");

        startTest();
        // Partial echo cut off at a byte boundary
        txBytes.push_back(`MSG_TYPE_ECHO);
        txBytes.push_back(8'd5);
        txBytes.push_back(8'($random(seed)));
        txBytes.push_back(8'($random(seed)));
        sendQueued();
        debugCs <= 1'b0;
        repeat (4 * HALF_CLKS) @(posedge clk);
        debugCs <= 1'b1;
        repeat (HALF_CLKS) @(posedge clk);
        queueMessage(`MSG_TYPE_ECHO, randRange(1, 5));
        sendQueued();
        drainReplies();
        endTest("Chip select drop");

        $display("Tests run: %0d, checks: %0d, errors: %0d", testIndex, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: debugTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_consts.svh"

module debugTop import debugPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic debugClk,
    input  logic debugCs,
    input  logic debugDi,
    output logic debugDo,
    output logic led0
);

    logic bitTick;
    logic linkActive;

    // Incoming message queue
    logic inPushValid;
    msgFrame_t inPushData;
    logic inFull;
    logic inPopReady;
    msgFrame_t inPopData;
    logic inEmpty;

    // Outgoing byte queue
    logic outPushValid;
    byte_t outPushData;
    logic outFull;
    logic outPopReady;
    byte_t outPopData;
    logic outEmpty;

    msgIf replyBus ();

    // ==================================================================
    // Receive path
    // ==================================================================
    serialRx rxUnit (
        .clk        (clk),
        .arstN      (arstN),
        .debugClk   (debugClk),
        .debugCs    (debugCs),
        .debugDi    (debugDi),
        .bitTick    (bitTick),
        .linkActive (linkActive),
        .pushValid  (inPushValid),
        .pushData   (inPushData),
        .full       (inFull)
    );

    msgFifo #(
        .DATA_WIDTH ($bits(msgFrame_t)),
        .DEPTH      (`DEBUG_IN_DEPTH)
    ) inQueue (
        .clk       (clk),
        .arstN     (arstN),
        .pushValid (inPushValid),
        .pushData  (inPushData),
        .full      (inFull),
        .popReady  (inPopReady),
        .popData   (inPopData),
        .empty     (inEmpty)
    );

    cmdHandler cmdUnit (
        .clk      (clk),
        .arstN    (arstN),
        .popData  (inPopData),
        .empty    (inEmpty),
        .popReady (inPopReady),
        .reply    (replyBus.source),
        .led0     (led0)
    );

    // ==================================================================
    // Transmit path
    // ==================================================================
    msgSender senderUnit (
        .clk       (clk),
        .arstN     (arstN),
        .req       (replyBus.sink),
        .pushValid (outPushValid),
        .pushData  (outPushData),
        .full      (outFull)
    );

    msgFifo #(
        .DATA_WIDTH ($bits(byte_t)),
        .DEPTH      (`DEBUG_OUT_DEPTH)
    ) outQueue (
        .clk       (clk),
        .arstN     (arstN),
        .pushValid (outPushValid),
        .pushData  (outPushData),
        .full      (outFull),
        .popReady  (outPopReady),
        .popData   (outPopData),
        .empty     (outEmpty)
    );

    serialTx txUnit (
        .clk        (clk),
        .arstN      (arstN),
        .bitTick    (bitTick),
        .linkActive (linkActive),
        .popData    (outPopData),
        .empty      (outEmpty),
        .popReady   (outPopReady),
        .debugDo    (debugDo)
    );

endmodule

`default_nettype wire

// File: debug_consts.svh
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// Largest payload kept per message, longer payloads are truncated
`define DEBUG_MAX_PAYLOAD 5

// Incoming queue holds whole messages, outgoing queue holds bytes
`define DEBUG_IN_DEPTH 4
`define DEBUG_OUT_DEPTH 16

// Flops between the serial pins and the clk domain logic
`define DEBUG_SYNC_STAGES 2

// Message types
`define MSG_TYPE_NOP 8'h00
`define MSG_TYPE_SET_LED 8'h01
`define MSG_TYPE_ECHO 8'h02

`endif

// File: msgFifo.sv
`timescale 1ns/1ps
`default_nettype none

module msgFifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  pushValid,
    input  logic [DATA_WIDTH-1:0] pushData,
    output logic                  full,
    input  logic                  popReady,
    output logic [DATA_WIDTH-1:0] popData,
    output logic                  empty
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [PTR_WIDTH-1:0] rdPtr;
    logic [CNT_WIDTH-1:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_WIDTH'(DEPTH));
    assign empty = (count == '0);
    assign doPush = pushValid && !full;
    assign doPop = popReady && !empty;

    // First word fallthrough, the head entry is always on the output
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Writer and reader live in other stages and must watch the flags
    noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        pushValid |-> !full);
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!arstN)
        popReady |-> !empty);

endmodule

`default_nettype wire

// File: msgIf.sv
`timescale 1ns/1ps
`default_nettype none

// Reply message from the command handler to the byte sequencer
interface msgIf import debugPkg::*; ();

    logic valid;
    logic ready;
    msgType_t msgType;
    payloadLen_t payloadLen;
    payload_t payload;

    // Command side, holds the fields while stalled
    modport source (
        output valid,
        output msgType,
        output payloadLen,
        output payload,
        input ready
    );

    // Sequencer side
    modport sink (
        input valid,
        input msgType,
        input payloadLen,
        input payload,
        output ready
    );

endinterface

`default_nettype wire

// File: msgSender.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_consts.svh"

module msgSender import debugPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    msgIf.sink    req,
    output logic  pushValid,
    output byte_t pushData,
    input  logic  full
);

    sendState_t state;
    msgType_t typeReg;
    payloadLen_t lenReg;
    payload_t payloadReg;
    logic accept;

    assign req.ready = (state == sendIdle);
    assign accept = req.valid && req.ready;

    // One byte per cycle unless the outgoing queue is full
    assign pushValid = (state != sendIdle) && !full;

    always_comb begin
        case (state)
            sendType: pushData = typeReg;
            sendLen: pushData = lenReg;
            default: pushData = payloadReg[7:0];
        endcase
    end

    // lenReg goes out as the length byte, then counts the payload down
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sendIdle;
            lenReg <= '0;
        end else begin
            case (state)
                sendIdle: begin
                    if (accept) begin
                        lenReg <= req.payloadLen;
                        state <= sendType;
                    end
                end
                sendType: begin
                    if (!full) begin
                        state <= sendLen;
                    end
                end
                sendLen: begin
                    if (!full) begin
                        state <= (lenReg == '0) ? sendIdle : sendPayload;
                    end
                end
                sendPayload: begin
                    if (!full) begin
                        lenReg <= lenReg - 1'b1;
                        if (lenReg == 8'd1) begin
                            state <= sendIdle;
                        end
                    end
                end
                default: state <= sendIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            typeReg <= req.msgType;
            payloadReg <= req.payload;
        end else if (state == sendPayload && !full) begin
            payloadReg <= payloadReg >> 8;
        end
    end

    // A stalled reply must not change under the sequencer
    holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
        req.valid && !req.ready |=> req.valid && $stable(req.msgType) &&
        $stable(req.payloadLen) && $stable(req.payload));

    lenInRange: assert property (@(posedge clk) disable iff (!arstN)
        req.valid |-> req.payloadLen <= `DEBUG_MAX_PAYLOAD);

endmodule

`default_nettype wire

// File: serialRx.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_consts.svh"

module serialRx import debugPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      debugClk,
    input  logic      debugCs,
    input  logic      debugDi,
    output logic      bitTick,
    output logic      linkActive,
    output logic      pushValid,
    output msgFrame_t pushData,
    input  logic      full
);

    localparam int SYNC_MSB = `DEBUG_SYNC_STAGES - 1;

    logic [SYNC_MSB:0] clkSync;
    logic [SYNC_MSB:0] csSync;
    logic [SYNC_MSB:0] diSync;
    logic clkPrev;
    logic [2:0] bitCnt;
    byte_t shiftReg;
    byte_t newByte;
    logic byteDone;
    rxState_t state;
    payloadLen_t lenReg;
    payloadLen_t payCnt;
    msgType_t typeReg;
    payloadLen_t storedLen;
    payload_t payloadReg;

    // ==================================================================
    // Pin synchronizers and edge detect
    // ==================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            clkSync <= '0;
            csSync <= '0;
            diSync <= '0;
            clkPrev <= 1'b0;
        end else begin
            clkSync <= {clkSync[SYNC_MSB-1:0], debugClk};
            csSync <= {csSync[SYNC_MSB-1:0], debugCs};
            diSync <= {diSync[SYNC_MSB-1:0], debugDi};
            clkPrev <= clkSync[SYNC_MSB];
        end
    end

    // Shared with the transmitter so both directions see the same edges
    assign linkActive = csSync[SYNC_MSB];
    assign bitTick = linkActive && clkSync[SYNC_MSB] && !clkPrev;

    assign newByte = {shiftReg[6:0], diSync[SYNC_MSB]};
    assign byteDone = bitTick && (bitCnt == 3'd7);

    // ==================================================================
    // Byte assembly and message framing
    // ==================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
            shiftReg <= '0;
            state <= rxIdle;
            lenReg <= '0;
            payCnt <= '0;
            pushValid <= 1'b0;
        end else if (!linkActive) begin
            // Chip select low abandons any partial message
            bitCnt <= '0;
            shiftReg <= '0;
            state <= rxIdle;
            pushValid <= 1'b0;
        end else begin
            if (bitTick) begin
                bitCnt <= bitCnt + 1'b1;
                shiftReg <= newByte;
            end
            pushValid <= 1'b0;
            case (state)
                rxIdle: state <= rxType;
                rxType: begin
                    // Nop bytes are skipped at any byte boundary
                    if (byteDone && newByte != `MSG_TYPE_NOP) begin
                        state <= rxLen;
                    end
                end
                rxLen: begin
                    if (byteDone) begin
                        lenReg <= newByte;
                        payCnt <= '0;
                        if (newByte == '0) begin
                            pushValid <= !full;
                            state <= rxPush;
                        end else begin
                            state <= rxPayload;
                        end
                    end
                end
                rxPayload: begin
                    if (byteDone) begin
                        payCnt <= payCnt + 1'b1;
                        if (payCnt + 1'b1 == lenReg) begin
                            pushValid <= !full;
                            state <= rxPush;
                        end
                    end
                end
                rxPush: state <= rxType;
                default: state <= rxIdle;
            endcase
        end
    end

    // Message fields
    always_ff @(posedge clk) begin
        if (byteDone) begin
            case (state)
                rxType: typeReg <= newByte;
                rxLen: begin
                    storedLen <= (newByte > payloadLen_t'(`DEBUG_MAX_PAYLOAD)) ?
                        payloadLen_t'(`DEBUG_MAX_PAYLOAD) : newByte;
                end
                rxPayload: begin
                    // Bytes past the last slot are counted but dropped
                    if (payCnt < `DEBUG_MAX_PAYLOAD) begin
                        payloadReg[{payCnt[2:0], 3'b000} +: 8] <= newByte;
                    end
                end
                default: ;
            endcase
        end
    end

    assign pushData = {payloadReg, storedLen, typeReg};

    // Full is sampled a cycle early, so a pop in between must not matter
    dropWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        full |-> !pushValid);

endmodule

`default_nettype wire

// File: serialTx.sv
`timescale 1ns/1ps
`default_nettype none

module serialTx import debugPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  bitTick,
    input  logic  linkActive,
    input  byte_t popData,
    input  logic  empty,
    output logic  popReady,
    output logic  debugDo
);

    logic [2:0] bitCnt;
    logic [6:0] shiftReg;
    logic slotStart;
    byte_t nextByte;

    // First rising edge of each byte slot
    assign slotStart = bitTick && (bitCnt == 3'd0);
    assign popReady = slotStart && !empty;

    // Nothing queued so the slot carries a zero byte
    assign nextByte = empty ? '0 : popData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
            shiftReg <= '0;
            debugDo <= 1'b0;
        end else if (!linkActive) begin
            bitCnt <= '0;
            shiftReg <= '0;
            debugDo <= 1'b0;
        end else if (bitTick) begin
            bitCnt <= bitCnt + 1'b1;
            if (slotStart) begin
                // MSB goes out right away, the rest waits in the shifter
                debugDo <= nextByte[7];
                shiftReg <= nextByte[6:0];
            end else begin
                debugDo <= shiftReg[6];
                shiftReg <= {shiftReg[5:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire
